//--- compile.f
hdl/snooper_pkg.sv
hdl/snoop_regs_pkg.sv
hdl/trace_buffer.sv
hdl/snooping_engine.sv
hdl/snoop_regs.sv
hdl/trace_snooper.sv
test/trace_snooper_sva.sv
test/tb_trace_snooper.sv

//--- test/tb_trace_snooper.sv
/*
 * Directed testbench for the trace snooper with a 16-entry buffer depth.
 * Expected buffer contents are kept in a model array.
 */
`timescale 1ns/1ps

module tb_trace_snooper;
   import snooper_pkg::*;
   import snoop_regs_pkg::*;

   localparam int unsigned AW         = 4;
   localparam int unsigned DEPTH      = 1 << AW;
   localparam int unsigned MAX_CYCLES = 4000;

   logic              clk_i;
   logic              rst_ni;
   logic              trace_valid_i;
   trace_u            trace_i;
   logic              bus_req_i;
   logic              bus_we_i;
   logic [BUS_AW-1:0] bus_addr_i;
   logic [BUS_DW-1:0] bus_wdata_i;
   logic [BUS_DW-1:0] bus_rdata_o;
   logic              bus_ack_o;

   logic [FIELD_W-1:0] model_mem [NUM_FIELDS][DEPTH];
   int unsigned        model_cnt;
   logic               model_en;
   logic               model_mode;
   int unsigned        errors;
   int unsigned        cycles = 0;

   trace_snooper #(
      .AddrWidth(AW)
   ) dut (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .trace_valid_i(trace_valid_i),
      .trace_i      (trace_i),
      .bus_req_i    (bus_req_i),
      .bus_we_i     (bus_we_i),
      .bus_addr_i   (bus_addr_i),
      .bus_wdata_i  (bus_wdata_i),
      .bus_rdata_o  (bus_rdata_o),
      .bus_ack_o    (bus_ack_o)
   );

   initial clk_i = 1'b0;
   always #4 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the bus handshake never completed", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   // Full four-phase transfer; read data is taken while ack is high
   task automatic bus_access(input logic we, input logic [BUS_AW-1:0] addr,
                             input logic [BUS_DW-1:0] wdata, output logic [BUS_DW-1:0] rdata);
      @(negedge clk_i);
      bus_req_i   = 1'b1;
      bus_we_i    = we;
      bus_addr_i  = addr;
      bus_wdata_i = wdata;
      while (bus_ack_o !== 1'b1) @(negedge clk_i);
      rdata     = bus_rdata_o;
      bus_req_i = 1'b0;
      bus_we_i  = 1'b0;
      while (bus_ack_o !== 1'b0) @(negedge clk_i);
   endtask

   task automatic bus_write(input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] data);
      logic [BUS_DW-1:0] unused;
      bus_access(1'b1, addr, data, unused);
   endtask

   task automatic bus_read(input logic [BUS_AW-1:0] addr, output logic [BUS_DW-1:0] data);
      bus_access(1'b0, addr, '0, data);
   endtask

   function automatic logic [BUS_AW-1:0] buf_addr(input int unsigned field, input int unsigned idx);
      logic [BUS_AW-1:0] addr;
      addr = '0;
      addr[BUF_REGION_BIT] = 1'b1;
      addr[FIELD_SEL_LSB +: FIELD_SEL_W] = field[FIELD_SEL_W-1:0];
      addr[AW-1:0] = idx[AW-1:0];
      return addr;
   endfunction

   function automatic logic [TRACE_W-1:0] random_trace();
      logic [TRACE_W-1:0] word;
      for (int k = 0; k < NUM_FIELDS; k++) begin
         word[k*FIELD_W +: FIELD_W] = $urandom;
      end
      return word;
   endfunction

   // One valid cycle, then the model follows the capture rules
   task automatic send_trace(input logic [TRACE_W-1:0] word);
      @(negedge clk_i);
      trace_valid_i = 1'b1;
      trace_i       = word;
      @(negedge clk_i);
      trace_valid_i = 1'b0;
      if (model_en) begin
         if (!model_mode) begin
            for (int k = 0; k < NUM_FIELDS; k++) begin
               model_mem[k][model_cnt] = word[k*FIELD_W +: FIELD_W];
            end
         end else begin
            model_mem[0][model_cnt] = word[FIELD_W-1:0];
         end
         model_cnt = (model_cnt + 1) % DEPTH;
      end
   endtask

   task automatic send_random(input int unsigned num);
      repeat (num) send_trace(random_trace());
   endtask

   task automatic write_ctrl(input logic [BUS_DW-1:0] data);
      bus_write(REG_CTRL, data);
      model_en   = data[CTRL_EN_BIT];
      model_mode = data[CTRL_MODE_BIT];
      if (data[CTRL_CNT_RST_BIT]) begin
         model_cnt = 0;
      end
   endtask

   task automatic check_regs();
      logic [BUS_DW-1:0] val;
      bus_read(REG_CTRL, val);
      check_value("CTRL", {30'b0, model_mode, model_en}, val);
      bus_read(REG_COUNT, val);
      check_value("COUNT", model_cnt, val);
   endtask

   task automatic check_entries(input int unsigned first, input int unsigned num);
      logic [BUS_DW-1:0] val;
      for (int idx = first; idx < first + num; idx++) begin
         for (int f = 0; f < NUM_FIELDS; f++) begin
            bus_read(buf_addr(f, idx), val);
            check_value($sformatf("buffer%0d[%0d]", f, idx), model_mem[f][idx], val);
         end
      end
   endtask

   task automatic test_reset();
      check_regs();
      send_random(3);
      check_regs();
   endtask

   task automatic test_address_mode();
      write_ctrl(32'h1);
      send_random(6);
      check_regs();
      check_entries(0, 6);
   endtask

   // Buffers 1 to 4 keep the address-mode data of the last test
   task automatic test_instruction_mode();
      write_ctrl(32'h7);
      send_random(5);
      check_regs();
      check_entries(0, 6);
   endtask

   task automatic test_wrap();
      write_ctrl(32'h5);
      send_random(19);
      check_regs();
      check_entries(0, DEPTH);
   endtask

   task automatic test_counter_clear();
      write_ctrl(32'h3);
      send_random(2);
      write_ctrl(32'h7);
      check_regs();
      send_random(1);
      check_regs();
      check_entries(0, 1);
   endtask

   task automatic test_unmapped();
      logic [BUS_DW-1:0] val;
      bus_read(16'h0002, val);
      check_value("reg[0x0002]", 32'h0, val);
      bus_read(16'h7fff, val);
      check_value("reg[0x7fff]", 32'h0, val);
      for (int f = NUM_FIELDS; f < 8; f++) begin
         bus_read(buf_addr(f, 0), val);
         check_value($sformatf("buffer%0d[0]", f), 32'h0, val);
      end
      bus_write(16'h0002, 32'hffff_ffff);
      bus_write(buf_addr(0, 0), 32'hdead_beef);
      bus_write(buf_addr(2, 5), 32'h1234_5678);
      check_regs();
      check_entries(0, DEPTH);
   endtask

   initial begin
      void'($urandom(72));
      rst_ni        = 1'b0;
      trace_valid_i = 1'b0;
      trace_i       = '0;
      bus_req_i     = 1'b0;
      bus_we_i      = 1'b0;
      bus_addr_i    = '0;
      bus_wdata_i   = '0;
      model_cnt     = 0;
      model_en      = 1'b0;
      model_mode    = 1'b0;
      errors        = 0;
      repeat (16) @(negedge clk_i);
      rst_ni = 1'b1;
      test_reset();
      test_address_mode();
      test_instruction_mode();
      test_wrap();
      test_counter_clear();
      test_unmapped();
      errors += dut.i_sva.fail_cnt;
      $display("Summary: %0d errors after %0d cycles", errors, cycles);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- test/trace_snooper_sva.sv
/*
 * Bound checks on the host handshake and the buffer write strobes.
 * Reports only through failing assertions.
 */
`timescale 1ns/1ps

module trace_snooper_sva (
   input logic                             clk_i,
   input logic                             rst_ni,
   input logic                             req_i,
   input logic                             ack_i,
   input logic                             snoop_en_i,
   input logic                             cnt_clr_i,
   input logic [snooper_pkg::NUM_FIELDS-1:0] buf_we_i
);

   // Number of failed checks in this run
   int unsigned fail_cnt = 0;

   // Ack may only come up in answer to a pending request
   ack_rise_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(ack_i) |-> $past(req_i))
      else begin
         fail_cnt++;
         $error("ack rose while req was low");
      end

   ack_fall_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (ack_i && !req_i) |=> !ack_i)
      else begin
         fail_cnt++;
         $error("ack did not fall on the cycle after req was seen low");
      end

   // A disabled snooper or a clear cycle must not touch the buffers
   no_write_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (!snoop_en_i || cnt_clr_i) |-> (buf_we_i == '0))
      else begin
         fail_cnt++;
         $error("buffer write strobe active while disabled or clearing");
      end

endmodule

bind trace_snooper trace_snooper_sva i_sva (
   .clk_i     (clk_i),
   .rst_ni    (rst_ni),
   .req_i     (bus_req_i),
   .ack_i     (bus_ack_o),
   .snoop_en_i(snoop_en),
   .cnt_clr_i (cnt_clr),
   .buf_we_i  (buf_we)
);

//--- hdl/trace_snooper.sv
/*
 * Trace snooper top: register block, engine and one buffer per field.
 * AddrWidth sets the buffer depth as a power of two and must be at most 12.
 * The trace input has no back-pressure.
 */
`timescale 1ns/1ps

module trace_snooper #(
   parameter int unsigned AddrWidth = 10
) (
   input  logic                              clk_i,
   input  logic                              rst_ni,
   input  logic                              trace_valid_i,
   input  snooper_pkg::trace_u               trace_i,
   input  logic                              bus_req_i,
   input  logic                              bus_we_i,
   input  logic [snoop_regs_pkg::BUS_AW-1:0] bus_addr_i,
   input  logic [snoop_regs_pkg::BUS_DW-1:0] bus_wdata_i,
   output logic [snoop_regs_pkg::BUS_DW-1:0] bus_rdata_o,
   output logic                              bus_ack_o
);
   import snooper_pkg::*;

   logic                                snoop_en;
   trace_mode_e                         trace_mode;
   logic                                cnt_clr;
   logic [AddrWidth-1:0]                cnt;
   logic [NUM_FIELDS-1:0]               rd_en;
   logic [AddrWidth-1:0]                rd_idx;
   logic [NUM_FIELDS-1:0][FIELD_W-1:0]  rd_data;
   logic [NUM_FIELDS-1:0]               buf_we;
   logic [AddrWidth-1:0]                buf_idx;
   logic [NUM_FIELDS-1:0][FIELD_W-1:0]  buf_wdata;

   snoop_regs #(
      .AddrWidth(AddrWidth)
   ) i_regs (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .bus_req_i   (bus_req_i),
      .bus_we_i    (bus_we_i),
      .bus_addr_i  (bus_addr_i),
      .bus_wdata_i (bus_wdata_i),
      .bus_rdata_o (bus_rdata_o),
      .bus_ack_o   (bus_ack_o),
      .snoop_en_o  (snoop_en),
      .trace_mode_o(trace_mode),
      .cnt_clr_o   (cnt_clr),
      .cnt_i       (cnt),
      .rd_en_o     (rd_en),
      .rd_idx_o    (rd_idx),
      .rd_data_i   (rd_data)
   );

   snooping_engine #(
      .AddrWidth(AddrWidth)
   ) i_engine (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .trace_valid_i(trace_valid_i),
      .trace_i      (trace_i),
      .snoop_en_i   (snoop_en),
      .trace_mode_i (trace_mode),
      .cnt_clr_i    (cnt_clr),
      .buf_we_o     (buf_we),
      .buf_idx_o    (buf_idx),
      .buf_wdata_o  (buf_wdata),
      .cnt_o        (cnt)
   );

   // All buffers share the write index and the host read index
   for (genvar i = 0; i < NUM_FIELDS; i++) begin : g_buf
      trace_buffer #(
         .AddrWidth(AddrWidth)
      ) i_buf (
         .clk_i    (clk_i),
         .we_i     (buf_we[i]),
         .wr_idx_i (buf_idx),
         .wr_data_i(buf_wdata[i]),
         .rd_en_i  (rd_en[i]),
         .rd_idx_i (rd_idx),
         .rd_data_o(rd_data[i])
      );
   end

endmodule

//--- hdl/snoop_regs.sv
/*
 * Host bus slave with a four-phase req/ack handshake.
 * Ack rises two edges after req is sampled and falls once req is seen low.
 * Buffer-space writes are ignored. AddrWidth must be at most 12.
 */
`timescale 1ns/1ps

module snoop_regs #(
   parameter int unsigned AddrWidth = 10
) (
   input  logic                                 clk_i,
   input  logic                                 rst_ni,
   input  logic                                 bus_req_i,
   input  logic                                 bus_we_i,
   input  logic [snoop_regs_pkg::BUS_AW-1:0]    bus_addr_i,
   input  logic [snoop_regs_pkg::BUS_DW-1:0]    bus_wdata_i,
   output logic [snoop_regs_pkg::BUS_DW-1:0]    bus_rdata_o,
   output logic                                 bus_ack_o,
   output logic                                 snoop_en_o,
   output snooper_pkg::trace_mode_e             trace_mode_o,
   output logic                                 cnt_clr_o,
   input  logic [AddrWidth-1:0]                 cnt_i,
   output logic [snooper_pkg::NUM_FIELDS-1:0]   rd_en_o,
   output logic [AddrWidth-1:0]                 rd_idx_o,
   input  logic [snooper_pkg::NUM_FIELDS-1:0][snooper_pkg::FIELD_W-1:0] rd_data_i
);
   import snooper_pkg::*;
   import snoop_regs_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      ACCESS,
      ACK
   } state_e;

   state_e                 state_q;
   logic                   ack_q;
   logic [BUS_DW-1:0]      rdata_q;
   logic [BUS_DW-1:0]      read_data;
   logic                   snoop_en_q;
   trace_mode_e            mode_q;
   logic                   cnt_clr_q;
   logic                   buf_sel;
   logic [FIELD_SEL_W-1:0] rd_field;
   logic                   respond;
   logic                   ctrl_wr;

   assign buf_sel  = bus_addr_i[BUF_REGION_BIT];
   assign rd_field = bus_addr_i[FIELD_SEL_LSB +: FIELD_SEL_W];
   assign rd_idx_o = bus_addr_i[AddrWidth-1:0];

   // First cycle in ACK: buffer data is out, response and writes land at its closing edge
   assign respond = (state_q == ACK) && !ack_q;
   assign ctrl_wr = respond && bus_we_i && (bus_addr_i == REG_CTRL);

   // Memory read is issued in the access cycle only
   always_comb begin
      rd_en_o = '0;
      if (state_q == ACCESS && buf_sel && !bus_we_i && rd_field < NUM_FIELDS) begin
         rd_en_o[rd_field] = 1'b1;
      end
   end

   always_comb begin
      read_data = '0;
      if (buf_sel) begin
         if (rd_field < NUM_FIELDS) begin
            read_data = rd_data_i[rd_field];
         end
      end else if (bus_addr_i == REG_CTRL) begin
         read_data[CTRL_EN_BIT]   = snoop_en_q;
         read_data[CTRL_MODE_BIT] = mode_q;
      end else if (bus_addr_i == REG_COUNT) begin
         read_data[AddrWidth-1:0] = cnt_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q <= IDLE;
         ack_q   <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (bus_req_i) begin
                  state_q <= ACCESS;
               end
            end
            ACCESS: state_q <= ACK;
            ACK: begin
               if (!ack_q) begin
                  ack_q <= 1'b1;
               end else if (!bus_req_i) begin
                  ack_q   <= 1'b0;
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (respond) begin
         rdata_q <= read_data;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         snoop_en_q <= 1'b0;
         mode_q     <= MODE_ADDRESS;
         cnt_clr_q  <= 1'b0;
      end else begin
         cnt_clr_q <= 1'b0;
         if (ctrl_wr) begin
            snoop_en_q <= bus_wdata_i[CTRL_EN_BIT];
            mode_q     <= trace_mode_e'(bus_wdata_i[CTRL_MODE_BIT]);
            cnt_clr_q  <= bus_wdata_i[CTRL_CNT_RST_BIT];
         end
      end
   end

   assign bus_ack_o    = ack_q;
   assign bus_rdata_o  = rdata_q;
   assign snoop_en_o   = snoop_en_q;
   assign trace_mode_o = mode_q;
   assign cnt_clr_o    = cnt_clr_q;

endmodule

//--- hdl/snooping_engine.sv
/*
 * Decodes retired-branch traces and writes them at the entry counter.
 * The trace stream cannot be stalled, so a trace arriving during the
 * clear pulse is dropped. The counter wraps at 2^AddrWidth entries.
 */
`timescale 1ns/1ps

module snooping_engine #(
   parameter int unsigned AddrWidth = 10
) (
   input  logic                                 clk_i,
   input  logic                                 rst_ni,
   input  logic                                 trace_valid_i,
   input  snooper_pkg::trace_u                  trace_i,
   input  logic                                 snoop_en_i,
   input  snooper_pkg::trace_mode_e             trace_mode_i,
   input  logic                                 cnt_clr_i,
   output logic [snooper_pkg::NUM_FIELDS-1:0]   buf_we_o,
   output logic [AddrWidth-1:0]                 buf_idx_o,
   output logic [snooper_pkg::NUM_FIELDS-1:0][snooper_pkg::FIELD_W-1:0] buf_wdata_o,
   output logic [AddrWidth-1:0]                 cnt_o
);
   import snooper_pkg::*;

   logic                 accept;
   logic [AddrWidth-1:0] cnt_q;

   // The clear pulse takes priority over any trace in the same cycle
   assign accept = trace_valid_i && snoop_en_i && !cnt_clr_i;

   always_comb begin
      buf_we_o    = '0;
      buf_wdata_o = '0;
      if (trace_mode_i == MODE_ADDRESS) begin
         buf_wdata_o[0] = trace_i.addr.pc_src_l;
         buf_wdata_o[1] = trace_i.addr.pc_src_h;
         buf_wdata_o[2] = trace_i.addr.pc_dst_l;
         buf_wdata_o[3] = trace_i.addr.pc_dst_h;
         buf_wdata_o[4] = trace_i.addr.metadata;
         buf_we_o       = {NUM_FIELDS{accept}};
      end else begin
         // Only buffer 0 changes, the other fields keep older address data
         buf_wdata_o[0] = trace_i.inst.opcode;
         buf_we_o[0]    = accept;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         cnt_q <= '0;
      end else if (cnt_clr_i) begin
         cnt_q <= '0;
      end else if (accept) begin
         if (cnt_q == {AddrWidth{1'b1}}) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // The write lands at the current entry, the counter then points past it
   assign buf_idx_o = cnt_q;
   assign cnt_o     = cnt_q;

endmodule

//--- hdl/trace_buffer.sv
/*
 * One field buffer: simple dual-port memory with a registered read port.
 * Read-first on a same-entry collision. Contents are undefined until written.
 */
`timescale 1ns/1ps

module trace_buffer #(
   parameter int unsigned AddrWidth = 10
) (
   input  logic                            clk_i,
   input  logic                            we_i,
   input  logic [AddrWidth-1:0]            wr_idx_i,
   input  logic [snooper_pkg::FIELD_W-1:0] wr_data_i,
   input  logic                            rd_en_i,
   input  logic [AddrWidth-1:0]            rd_idx_i,
   output logic [snooper_pkg::FIELD_W-1:0] rd_data_o
);
   import snooper_pkg::*;

   logic [FIELD_W-1:0] mem [2**AddrWidth];

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[wr_idx_i] <= wr_data_i;
      end
      // Output holds its last value while no read is issued
      if (rd_en_i) begin
         rd_data_o <= mem[rd_idx_i];
      end
   end

endmodule

//--- hdl/snoop_regs_pkg.sv
/*
 * Host bus address map and CTRL bit positions.
 * Addresses are word indices, not byte addresses.
 */
package snoop_regs_pkg;

   localparam int unsigned BUS_AW = 16;
   localparam int unsigned BUS_DW = 32;

   // Address bit 15 splits register space from buffer space
   localparam int unsigned BUF_REGION_BIT = 15;

   // In buffer space bits 14:12 pick the field, the low bits pick the entry
   localparam int unsigned FIELD_SEL_LSB = 12;
   localparam int unsigned FIELD_SEL_W   = 3;

   localparam logic [BUS_AW-1:0] REG_CTRL  = 16'h0000;
   localparam logic [BUS_AW-1:0] REG_COUNT = 16'h0001;

   localparam int unsigned CTRL_EN_BIT      = 0;
   localparam int unsigned CTRL_MODE_BIT    = 1;
   // Write-one pulse that is never stored and reads back as 0
   localparam int unsigned CTRL_CNT_RST_BIT = 2;

endpackage

//--- hdl/snooper_pkg.sv
/*
 * Trace word layout shared by the snooper RTL and its testbench.
 * Field count and widths are fixed by the trace format and cannot be
 * overridden per instance.
 */
package snooper_pkg;

   localparam int unsigned NUM_FIELDS = 5;
   localparam int unsigned FIELD_W    = 32;
   localparam int unsigned TRACE_W    = NUM_FIELDS * FIELD_W;

   // Selects how a trace word is decoded and which buffers it fills
   typedef enum logic {
      MODE_ADDRESS     = 1'b0,
      MODE_INSTRUCTION = 1'b1
   } trace_mode_e;

   // Retired branch record with one field per buffer.
   // pc_src_l sits in the low word and lands in buffer 0
   typedef struct packed {
      logic [FIELD_W-1:0] metadata;
      logic [FIELD_W-1:0] pc_dst_h;
      logic [FIELD_W-1:0] pc_dst_l;
      logic [FIELD_W-1:0] pc_src_h;
      logic [FIELD_W-1:0] pc_src_l;
   } addr_rec_t;

   // Instruction view keeps only the opcode in the low word
   typedef struct packed {
      logic [TRACE_W-FIELD_W-1:0] reserved;
      logic [FIELD_W-1:0]         opcode;
   } inst_rec_t;

   // The same trace word read two ways, picked by the trace mode
   typedef union packed {
      addr_rec_t addr;
      inst_rec_t inst;
   } trace_u;

endpackage
